/* src.f */
source/traffic_pkg.sv
source/csr_bus_if.sv
source/st_link_if.sv
source/csr_address_decoder.sv
source/path_select_csr.sv
source/channel_stream_switch.sv
source/eth_traffic_router.sv
verif/stream_switch_checker.sv
verif/tb_eth_traffic_router.sv

/* Bender.yml */
package:
  name: eth_traffic_router

sources:
  - files:
      - source/traffic_pkg.sv
      - source/csr_bus_if.sv
      - source/st_link_if.sv
      - source/csr_address_decoder.sv
      - source/path_select_csr.sv
      - source/channel_stream_switch.sv
      - source/eth_traffic_router.sv
  - target: test
    files:
      - verif/stream_switch_checker.sv
      - verif/tb_eth_traffic_router.sv

/* verif/tb_eth_traffic_router.sv */
/*
 * Testbench for the traffic routing fabric.
 * Emulates the external bus targets, the traffic engines and the MAC with
 * LFSR driven stimulus and checks every cycle against a model of the
 * decoder, select register and packet-boundary stream switch.
 */

`timescale 1ns/1ps

module tb_eth_traffic_router;
	import traffic_pkg::*;

	localparam int NCH = num_channels_default;

	logic clk;
	logic rst;
	logic avl_mm_read;
	logic avl_mm_write;
	logic [csr_addr_w-1:0] avl_mm_address;
	csr_word_t avl_mm_writedata;
	csr_word_t avl_mm_readdata;
	logic avl_mm_waitrequest;
	logic ptp_read;
	logic ptp_write;
	logic [7:0] ptp_address;
	csr_word_t ptp_readdata;
	logic ptp_waitrequest;
	logic [NCH-1:0] std_read;
	logic [NCH-1:0] std_write;
	logic [offset_w-1:0] std_address;
	csr_word_t [NCH-1:0] std_readdata;
	logic [NCH-1:0] std_waitrequest;
	csr_word_t writedata_out;
	st_data_t [NCH-1:0] ptp_tx_data, std_tx_data, mac_tx_data;
	st_data_t [NCH-1:0] ptp_rx_data, std_rx_data, mac_rx_data;
	logic [NCH-1:0][st_empty_w-1:0] ptp_tx_empty, std_tx_empty, mac_tx_empty;
	logic [NCH-1:0][st_empty_w-1:0] ptp_rx_empty, std_rx_empty, mac_rx_empty;
	logic [NCH-1:0][tx_error_w-1:0] ptp_tx_error, std_tx_error, mac_tx_error;
	logic [NCH-1:0][rx_error_w-1:0] ptp_rx_error, std_rx_error, mac_rx_error;
	logic [NCH-1:0] ptp_tx_sop, ptp_tx_eop, ptp_tx_valid, ptp_tx_ready;
	logic [NCH-1:0] std_tx_sop, std_tx_eop, std_tx_valid, std_tx_ready;
	logic [NCH-1:0] mac_tx_sop, mac_tx_eop, mac_tx_valid, mac_tx_ready;
	logic [NCH-1:0] ptp_rx_sop, ptp_rx_eop, ptp_rx_valid, ptp_rx_ready;
	logic [NCH-1:0] std_rx_sop, std_rx_eop, std_rx_valid, std_rx_ready;
	logic [NCH-1:0] mac_rx_sop, mac_rx_eop, mac_rx_valid, mac_rx_ready;

	// pending beat per source
	// index 0 is ptp tx, 1 std tx and 2 mac rx
	st_data_t bd [NCH][3];
	logic [2:0] be [NCH][3];
	logic [5:0] berr [NCH][3];
	logic bs [NCH][3];
	logic bp [NCH][3];
	logic bv [NCH][3];
	int left [NCH][3];

	// switch model
	logic m_active [NCH];
	logic m_txo [NCH];
	logic m_rxo [NCH];
	logic m_req;

	logic [15:0] lfsr = 16'd62;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int beats = 0;

	eth_traffic_router #(.NUM_CHANNELS(NCH)) i_eth_traffic_router (.*);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic b;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			b = lfsr[0];
			lfsr = lfsr >> 1;
			if (b)
				lfsr = lfsr ^ 16'hB400;
			r = {r[30:0], b};
		end
		return r;
	endfunction

	//////////////////////////////
	// compare tasks
	task automatic compare_word(input string what, input csr_word_t got, input csr_word_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_path(input string what, input logic [NCH-1:0] got,
		input logic [NCH-1:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic compare_beat(input string what, input st_data_t gd, input st_data_t ed,
		input logic [2:0] ge, input logic [2:0] ee, input logic gs, input logic es,
		input logic gp, input logic ep, input logic [5:0] gr, input logic [5:0] er);
		checks++;
		if ({gd, ge, gs, gp, gr} !== {ed, ee, es, ep, er})
		begin
			errors++;
			$display("Mismatch at %0t: %s got %h/%0d/%b%b/%h expected %h/%0d/%b%b/%h",
				$time, what, gd, ge, gs, gp, gr, ed, ee, es, ep, er);
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("Timeout while waiting for %s", what);
		$display("TB FAILED");
		$finish;
	endtask

	task automatic report(input string name, input int err_before);
		tests++;
		$display("test %-22s %s (%0d errors)", name,
			(errors == err_before) ? "ok" : "failed", errors - err_before);
	endtask

	//////////////////////////////
	// bus access to an emulated target region with delay cycles of waitrequest
	task automatic host_access(input logic [1:0] region, input logic [11:0] offset,
		input logic is_write, input int delay);
		csr_addr_u u;
		csr_word_t wd;
		csr_word_t rd;
		logic [5:0] exp_strb;
		int cnt;
		u.split.region = region;
		u.split.offset = offset;
		wd = rand_bits(32);
		rd = rand_bits(32);
		exp_strb = '0;
		if (region == region_ptp)
			exp_strb[5:4] = {~is_write, is_write};
		else if (region == region_std0)
			exp_strb[1:0] = {~is_write, is_write};
		else
			exp_strb[3:2] = {~is_write, is_write};
		avl_mm_address = u.raw;
		avl_mm_writedata = wd;
		avl_mm_read = ~is_write;
		avl_mm_write = is_write;
		ptp_readdata = (region == region_ptp) ? rd : ~rd;
		std_readdata[0] = (region == region_std0) ? rd : ~rd;
		std_readdata[1] = (region == region_std1) ? rd : ~rd;
		cnt = 0;
		while (1)
		begin
			ptp_waitrequest = (cnt < delay);
			std_waitrequest = {NCH{cnt < delay}};
			#2;
			compare_word("strobes", csr_word_t'({ptp_read, ptp_write, std_read[1],
				std_write[1], std_read[0], std_write[0]}), csr_word_t'(exp_strb));
			if (region == region_ptp)
				compare_word("ptp address", csr_word_t'(ptp_address), csr_word_t'(offset[7:0]));
			else
				compare_word("std address", csr_word_t'(std_address), csr_word_t'(offset));
			if (is_write)
				compare_word("writedata", writedata_out, wd);
			compare_word("waitrequest", csr_word_t'(avl_mm_waitrequest),
				csr_word_t'(cnt < delay));
			if (cnt >= delay)
			begin
				if (!is_write)
					compare_word("readdata", avl_mm_readdata, rd);
				break;
			end
			@(posedge clk);
			#1;
			cnt++;
			if (cnt > 20)
				timeout_fail("target waitrequest");
		end
		@(posedge clk);
		#1;
		avl_mm_read = 1'b0;
		avl_mm_write = 1'b0;
	endtask

	// select register access returning read data and latency
	task automatic select_access(input logic is_write, input logic offset,
		input csr_word_t wd, output csr_word_t rd, output int cycles);
		csr_addr_u u;
		u.split.region = region_select;
		u.split.offset = offset_w'(offset);
		avl_mm_address = u.raw;
		avl_mm_writedata = wd;
		avl_mm_read = ~is_write;
		avl_mm_write = is_write;
		cycles = 0;
		while (1)
		begin
			#2;
			if (!avl_mm_waitrequest)
				break;
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > 10)
				timeout_fail("select register waitrequest");
		end
		rd = avl_mm_readdata;
		@(posedge clk);
		#1;
		avl_mm_read = 1'b0;
		avl_mm_write = 1'b0;
	endtask

	//////////////////////////////
	// one stream cycle of sources, sinks and model
	task automatic next_beats(input logic allow_new);
		for (int ch = 0; ch < NCH; ch++)
			for (int s = 0; s < 3; s++)
				if (!bv[ch][s] && (allow_new || left[ch][s] > 0) && rand_bits(1))
				begin
					bs[ch][s] = (left[ch][s] == 0);
					if (left[ch][s] == 0)
						left[ch][s] = 1 + rand_bits(2);
					bp[ch][s] = (left[ch][s] == 1);
					left[ch][s]--;
					bd[ch][s] = {rand_bits(32), rand_bits(32)};
					be[ch][s] = rand_bits(3);
					berr[ch][s] = rand_bits(6);
					bv[ch][s] = 1'b1;
				end
	endtask

	task automatic run_cycle(input logic allow_new, input logic do_write, input logic wval);
		logic [NCH-1:0] e_ptr, e_str, e_prv, e_srv, e_mrr, e_mtv, tx_x, rx_x;
		logic a;
		logic st;
		logic sr;
		logic bnd;
		csr_addr_u u;
		next_beats(allow_new);
		for (int ch = 0; ch < NCH; ch++)
		begin
			mac_tx_ready[ch] = allow_new ? (rand_bits(2) != 0) : 1'b1;
			ptp_rx_ready[ch] = allow_new ? (rand_bits(2) != 0) : 1'b1;
			std_rx_ready[ch] = allow_new ? (rand_bits(2) != 0) : 1'b1;
			ptp_tx_data[ch] = bd[ch][0];
			ptp_tx_empty[ch] = be[ch][0];
			ptp_tx_sop[ch] = bs[ch][0];
			ptp_tx_eop[ch] = bp[ch][0];
			ptp_tx_error[ch] = berr[ch][0][0];
			ptp_tx_valid[ch] = bv[ch][0];
			std_tx_data[ch] = bd[ch][1];
			std_tx_empty[ch] = be[ch][1];
			std_tx_sop[ch] = bs[ch][1];
			std_tx_eop[ch] = bp[ch][1];
			std_tx_error[ch] = berr[ch][1][0];
			std_tx_valid[ch] = bv[ch][1];
			mac_rx_data[ch] = bd[ch][2];
			mac_rx_empty[ch] = be[ch][2];
			mac_rx_sop[ch] = bs[ch][2];
			mac_rx_eop[ch] = bp[ch][2];
			mac_rx_error[ch] = berr[ch][2];
			mac_rx_valid[ch] = bv[ch][2];
		end
		u.split.region = region_select;
		u.split.offset = '0;
		avl_mm_address = u.raw;
		avl_mm_writedata = csr_word_t'(wval);
		avl_mm_write = do_write;
		#2;
		if (do_write)
			compare_word("select write wait", csr_word_t'(avl_mm_waitrequest), '0);
		for (int ch = 0; ch < NCH; ch++)
		begin
			// std path takes source index 1 and ptp path index 0
			a = m_active[ch];
			e_ptr[ch] = (a == path_ptp) & mac_tx_ready[ch];
			e_str[ch] = (a == path_std) & mac_tx_ready[ch];
			e_prv[ch] = (a == path_ptp) & bv[ch][2];
			e_srv[ch] = (a == path_std) & bv[ch][2];
			e_mrr[ch] = a ? std_rx_ready[ch] : ptp_rx_ready[ch];
			e_mtv[ch] = bv[ch][a];
			if (bv[ch][a])
				compare_beat("mac tx beat", mac_tx_data[ch], bd[ch][a], mac_tx_empty[ch],
					be[ch][a], mac_tx_sop[ch], bs[ch][a], mac_tx_eop[ch], bp[ch][a],
					6'(mac_tx_error[ch]), 6'(berr[ch][a][0]));
			if (bv[ch][2] && a == path_ptp)
				compare_beat("ptp rx beat", ptp_rx_data[ch], bd[ch][2], ptp_rx_empty[ch],
					be[ch][2], ptp_rx_sop[ch], bs[ch][2], ptp_rx_eop[ch], bp[ch][2],
					ptp_rx_error[ch], berr[ch][2]);
			if (bv[ch][2] && a == path_std)
				compare_beat("std rx beat", std_rx_data[ch], bd[ch][2], std_rx_empty[ch],
					be[ch][2], std_rx_sop[ch], bs[ch][2], std_rx_eop[ch], bp[ch][2],
					std_rx_error[ch], berr[ch][2]);
			tx_x[ch] = bv[ch][a] & mac_tx_ready[ch];
			rx_x[ch] = bv[ch][2] & e_mrr[ch];
		end
		compare_path("mac tx valid", mac_tx_valid, e_mtv);
		compare_path("ptp tx ready", ptp_tx_ready, e_ptr);
		compare_path("std tx ready", std_tx_ready, e_str);
		compare_path("ptp rx valid", ptp_rx_valid, e_prv);
		compare_path("std rx valid", std_rx_valid, e_srv);
		compare_path("mac rx ready", mac_rx_ready, e_mrr);
		@(posedge clk);
		for (int ch = 0; ch < NCH; ch++)
		begin
			a = m_active[ch];
			st = tx_x[ch] & bs[ch][a] & ~bp[ch][a];
			sr = rx_x[ch] & bs[ch][2] & ~bp[ch][2];
			bnd = ~m_txo[ch] & ~m_rxo[ch] & ~st & ~sr;
			if (tx_x[ch])
				m_txo[ch] = st | (m_txo[ch] & ~bp[ch][a]);
			if (rx_x[ch])
				m_rxo[ch] = sr | (m_rxo[ch] & ~bp[ch][2]);
			if (bnd)
				m_active[ch] = m_req;
			if (tx_x[ch])
				bv[ch][a] = 1'b0;
			if (rx_x[ch])
				bv[ch][2] = 1'b0;
			beats += tx_x[ch] + rx_x[ch];
		end
		if (do_write)
			m_req = wval;
		#1;
		avl_mm_write = 1'b0;
	endtask

	// finish open packets and compare the active paths read back
	task automatic drain_and_check();
		int cnt;
		logic busy;
		logic a;
		csr_word_t rd;
		int lat;
		logic [NCH-1:0] exp;
		cnt = 0;
		busy = 1'b1;
		while (busy)
		begin
			run_cycle(1'b0, 1'b0, 1'b0);
			busy = 1'b0;
			for (int ch = 0; ch < NCH; ch++)
			begin
				// the idle engine keeps its held beat until the path changes
				a = m_active[ch];
				busy |= (a != m_req) | bv[ch][a] | (left[ch][a] != 0);
				busy |= bv[ch][2] | (left[ch][2] != 0);
			end
			cnt++;
			if (cnt > 200)
				timeout_fail("streams to drain");
		end
		run_cycle(1'b0, 1'b0, 1'b0);
		select_access(1'b0, 1'b1, '0, rd, lat);
		for (int ch = 0; ch < NCH; ch++)
			exp[ch] = m_active[ch];
		compare_path("active paths", rd[NCH-1:0], exp);
	endtask

	//////////////////////////////
	// sequence
	initial
	begin
		int e0;
		int lat;
		int gap;
		csr_word_t rd;
		logic [1:0] region;
		rst = 1'b1;
		{avl_mm_read, avl_mm_write, avl_mm_address, avl_mm_writedata} = '0;
		{ptp_readdata, ptp_waitrequest, std_readdata, std_waitrequest} = '0;
		{ptp_tx_data, ptp_tx_empty, ptp_tx_sop, ptp_tx_eop, ptp_tx_error, ptp_tx_valid} = '0;
		{std_tx_data, std_tx_empty, std_tx_sop, std_tx_eop, std_tx_error, std_tx_valid} = '0;
		{mac_rx_data, mac_rx_empty, mac_rx_sop, mac_rx_eop, mac_rx_error, mac_rx_valid} = '0;
		{mac_tx_ready, ptp_rx_ready, std_rx_ready} = '0;
		for (int ch = 0; ch < NCH; ch++)
		begin
			m_active[ch] = path_std;
			m_txo[ch] = 1'b0;
			m_rxo[ch] = 1'b0;
			for (int s = 0; s < 3; s++)
			begin
				bv[ch][s] = 1'b0;
				left[ch][s] = 0;
			end
		end
		m_req = path_std;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;

		e0 = errors;
		for (int i = 0; i < 60; i++)
		begin
			region = rand_bits(2);
			if (region == region_select)
				region = region_ptp;
			host_access(region, rand_bits(12), rand_bits(1), rand_bits(2));
		end
		report("region routing", e0);

		e0 = errors;
		select_access(1'b0, 1'b0, '0, rd, lat);
		compare_word("reset path", rd, csr_word_t'(path_std));
		compare_word("read latency", csr_word_t'(lat), 1);
		select_access(1'b0, 1'b1, '0, rd, lat);
		compare_path("reset active", rd[NCH-1:0], {NCH{path_std}});
		select_access(1'b1, 1'b0, csr_word_t'(path_ptp), rd, lat);
		compare_word("write latency", csr_word_t'(lat), 0);
		select_access(1'b0, 1'b0, '0, rd, lat);
		compare_word("path readback", rd, csr_word_t'(path_ptp));
		select_access(1'b0, 1'b1, '0, rd, lat);
		compare_path("active after write", rd[NCH-1:0], {NCH{path_ptp}});
		for (int ch = 0; ch < NCH; ch++)
			m_active[ch] = path_ptp;
		m_req = path_ptp;
		report("select register", e0);

		e0 = errors;
		for (int i = 0; i < 300; i++)
			run_cycle(1'b1, 1'b0, 1'b0);
		drain_and_check();
		report("ptp path streams", e0);

		e0 = errors;
		run_cycle(1'b1, 1'b1, path_std);
		for (int i = 0; i < 300; i++)
			run_cycle(1'b1, 1'b0, 1'b0);
		drain_and_check();
		report("std path streams", e0);

		// path writes land at random points and often inside packets
		e0 = errors;
		gap = 0;
		for (int i = 0; i < 600; i++)
		begin
			if (gap == 0)
			begin
				gap = 3 + rand_bits(3);
				run_cycle(1'b1, 1'b1, ~m_req);
			end
			else
			begin
				gap--;
				run_cycle(1'b1, 1'b0, 1'b0);
			end
		end
		drain_and_check();
		report("boundary switching", e0);

		$display("tests %0d, checks %0d, beats %0d, errors %0d", tests, checks, beats, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

/* verif/stream_switch_checker.sv */
/*
 * Concurrent assertions for one channel stream switch.
 * Bound into every channel_stream_switch instance, it watches the
 * idle engine's handshake and the packet-boundary rule for path changes.
 */

`timescale 1ns/1ps

module stream_switch_checker (
	input logic clk,
	input logic rst,
	input logic active_q,
	input logic use_ptp,
	input logic tx_open,
	input logic rx_open,
	input logic ptp_tx_ready,
	input logic std_tx_ready,
	input logic ptp_rx_valid,
	input logic std_rx_valid
);

	// idle transmit engine is never accepted
	idle_tx_held: assert property (@(posedge clk) disable iff (rst)
		use_ptp ? !std_tx_ready : !ptp_tx_ready)
		else $error("idle transmit engine saw ready");

	// idle receive engine never offered a beat
	idle_rx_quiet: assert property (@(posedge clk) disable iff (rst)
		use_ptp ? !std_rx_valid : !ptp_rx_valid)
		else $error("idle receive engine saw valid");

	path_kept_in_packet: assert property (@(posedge clk) disable iff (rst)
		(tx_open || rx_open) |=> $stable(active_q))
		else $error("active path changed inside a packet");

endmodule

bind channel_stream_switch stream_switch_checker i_stream_switch_checker (
	.clk(clk),
	.rst(rst),
	.active_q(active_q),
	.use_ptp(use_ptp),
	.tx_open(tx_open),
	.rx_open(rx_open),
	.ptp_tx_ready(ptp_tx.ready),
	.std_tx_ready(std_tx.ready),
	.ptp_rx_valid(ptp_rx.valid),
	.std_rx_valid(std_rx.valid)
);

/* source/eth_traffic_router.sv */
/*
 * Traffic routing fabric for the Ethernet test design.
 * Decodes the host control bus, holds the path-select register and
 * switches each channel's MAC streams between the ptp and standard
 * traffic engines, which sit outside on plain ports.
 */

`timescale 1ns/1ps

module eth_traffic_router #(
	parameter int NUM_CHANNELS = traffic_pkg::num_channels_default
) (
	input logic clk,
	input logic rst,

	// host bus
	input logic avl_mm_read,
	input logic avl_mm_write,
	input logic [traffic_pkg::csr_addr_w-1:0] avl_mm_address,
	input traffic_pkg::csr_word_t avl_mm_writedata,
	output traffic_pkg::csr_word_t avl_mm_readdata,
	output logic avl_mm_waitrequest,

	// exported engine buses
	output logic ptp_read,
	output logic ptp_write,
	output logic [7:0] ptp_address,
	input traffic_pkg::csr_word_t ptp_readdata,
	input logic ptp_waitrequest,
	output logic [NUM_CHANNELS-1:0] std_read,
	output logic [NUM_CHANNELS-1:0] std_write,
	output logic [traffic_pkg::offset_w-1:0] std_address,
	input traffic_pkg::csr_word_t [NUM_CHANNELS-1:0] std_readdata,
	input logic [NUM_CHANNELS-1:0] std_waitrequest,
	output traffic_pkg::csr_word_t writedata_out,

	// engine transmit streams
	input traffic_pkg::st_data_t [NUM_CHANNELS-1:0] ptp_tx_data,
	input logic [NUM_CHANNELS-1:0][traffic_pkg::st_empty_w-1:0] ptp_tx_empty,
	input logic [NUM_CHANNELS-1:0] ptp_tx_sop,
	input logic [NUM_CHANNELS-1:0] ptp_tx_eop,
	input logic [NUM_CHANNELS-1:0][traffic_pkg::tx_error_w-1:0] ptp_tx_error,
	input logic [NUM_CHANNELS-1:0] ptp_tx_valid,
	output logic [NUM_CHANNELS-1:0] ptp_tx_ready,
	input traffic_pkg::st_data_t [NUM_CHANNELS-1:0] std_tx_data,
	input logic [NUM_CHANNELS-1:0][traffic_pkg::st_empty_w-1:0] std_tx_empty,
	input logic [NUM_CHANNELS-1:0] std_tx_sop,
	input logic [NUM_CHANNELS-1:0] std_tx_eop,
	input logic [NUM_CHANNELS-1:0][traffic_pkg::tx_error_w-1:0] std_tx_error,
	input logic [NUM_CHANNELS-1:0] std_tx_valid,
	output logic [NUM_CHANNELS-1:0] std_tx_ready,

	// engine receive streams
	output traffic_pkg::st_data_t [NUM_CHANNELS-1:0] ptp_rx_data,
	output logic [NUM_CHANNELS-1:0][traffic_pkg::st_empty_w-1:0] ptp_rx_empty,
	output logic [NUM_CHANNELS-1:0] ptp_rx_sop,
	output logic [NUM_CHANNELS-1:0] ptp_rx_eop,
	output logic [NUM_CHANNELS-1:0][traffic_pkg::rx_error_w-1:0] ptp_rx_error,
	output logic [NUM_CHANNELS-1:0] ptp_rx_valid,
	input logic [NUM_CHANNELS-1:0] ptp_rx_ready,
	output traffic_pkg::st_data_t [NUM_CHANNELS-1:0] std_rx_data,
	output logic [NUM_CHANNELS-1:0][traffic_pkg::st_empty_w-1:0] std_rx_empty,
	output logic [NUM_CHANNELS-1:0] std_rx_sop,
	output logic [NUM_CHANNELS-1:0] std_rx_eop,
	output logic [NUM_CHANNELS-1:0][traffic_pkg::rx_error_w-1:0] std_rx_error,
	output logic [NUM_CHANNELS-1:0] std_rx_valid,
	input logic [NUM_CHANNELS-1:0] std_rx_ready,

	// MAC side
	output traffic_pkg::st_data_t [NUM_CHANNELS-1:0] mac_tx_data,
	output logic [NUM_CHANNELS-1:0][traffic_pkg::st_empty_w-1:0] mac_tx_empty,
	output logic [NUM_CHANNELS-1:0] mac_tx_sop,
	output logic [NUM_CHANNELS-1:0] mac_tx_eop,
	output logic [NUM_CHANNELS-1:0][traffic_pkg::tx_error_w-1:0] mac_tx_error,
	output logic [NUM_CHANNELS-1:0] mac_tx_valid,
	input logic [NUM_CHANNELS-1:0] mac_tx_ready,
	input traffic_pkg::st_data_t [NUM_CHANNELS-1:0] mac_rx_data,
	input logic [NUM_CHANNELS-1:0][traffic_pkg::st_empty_w-1:0] mac_rx_empty,
	input logic [NUM_CHANNELS-1:0] mac_rx_sop,
	input logic [NUM_CHANNELS-1:0] mac_rx_eop,
	input logic [NUM_CHANNELS-1:0][traffic_pkg::rx_error_w-1:0] mac_rx_error,
	input logic [NUM_CHANNELS-1:0] mac_rx_valid,
	output logic [NUM_CHANNELS-1:0] mac_rx_ready
);
	import traffic_pkg::*;

	logic requested_path;
	logic [NUM_CHANNELS-1:0] active_path;

	csr_bus_if #(.ADDR_W(csr_addr_w)) host_bus ();
	csr_bus_if #(.ADDR_W(1)) select_bus ();

	assign host_bus.read = avl_mm_read;
	assign host_bus.write = avl_mm_write;
	assign host_bus.address = avl_mm_address;
	assign host_bus.writedata = avl_mm_writedata;
	assign avl_mm_readdata = host_bus.readdata;
	assign avl_mm_waitrequest = host_bus.waitrequest;

	//////////////////////////////
	// control path
	csr_address_decoder #(.NUM_CHANNELS(NUM_CHANNELS)) i_csr_address_decoder (
		.clk(clk),
		.rst(rst),
		.host(host_bus.target),
		.select_bus(select_bus.host),
		.ptp_read(ptp_read),
		.ptp_write(ptp_write),
		.ptp_address(ptp_address),
		.ptp_readdata(ptp_readdata),
		.ptp_waitrequest(ptp_waitrequest),
		.std_read(std_read),
		.std_write(std_write),
		.std_address(std_address),
		.std_readdata(std_readdata),
		.std_waitrequest(std_waitrequest),
		.writedata_out(writedata_out)
	);

	path_select_csr #(.NUM_CHANNELS(NUM_CHANNELS)) i_path_select_csr (
		.clk(clk),
		.rst(rst),
		.bus(select_bus.target),
		.active_path(active_path),
		.requested_path(requested_path)
	);

	//////////////////////////////
	// one stream switch per channel
	for (genvar ch = 0; ch < NUM_CHANNELS; ch++)
	begin : g_channel
		st_link_if #(.ERROR_W(tx_error_w)) ptp_tx_link ();
		st_link_if #(.ERROR_W(tx_error_w)) std_tx_link ();
		st_link_if #(.ERROR_W(tx_error_w)) mac_tx_link ();
		st_link_if #(.ERROR_W(rx_error_w)) mac_rx_link ();
		st_link_if #(.ERROR_W(rx_error_w)) ptp_rx_link ();
		st_link_if #(.ERROR_W(rx_error_w)) std_rx_link ();

		assign ptp_tx_link.data = ptp_tx_data[ch];
		assign ptp_tx_link.empty = ptp_tx_empty[ch];
		assign ptp_tx_link.sop = ptp_tx_sop[ch];
		assign ptp_tx_link.eop = ptp_tx_eop[ch];
		assign ptp_tx_link.error = ptp_tx_error[ch];
		assign ptp_tx_link.valid = ptp_tx_valid[ch];
		assign ptp_tx_ready[ch] = ptp_tx_link.ready;

		assign std_tx_link.data = std_tx_data[ch];
		assign std_tx_link.empty = std_tx_empty[ch];
		assign std_tx_link.sop = std_tx_sop[ch];
		assign std_tx_link.eop = std_tx_eop[ch];
		assign std_tx_link.error = std_tx_error[ch];
		assign std_tx_link.valid = std_tx_valid[ch];
		assign std_tx_ready[ch] = std_tx_link.ready;

		assign mac_tx_data[ch] = mac_tx_link.data;
		assign mac_tx_empty[ch] = mac_tx_link.empty;
		assign mac_tx_sop[ch] = mac_tx_link.sop;
		assign mac_tx_eop[ch] = mac_tx_link.eop;
		assign mac_tx_error[ch] = mac_tx_link.error;
		assign mac_tx_valid[ch] = mac_tx_link.valid;
		assign mac_tx_link.ready = mac_tx_ready[ch];

		assign mac_rx_link.data = mac_rx_data[ch];
		assign mac_rx_link.empty = mac_rx_empty[ch];
		assign mac_rx_link.sop = mac_rx_sop[ch];
		assign mac_rx_link.eop = mac_rx_eop[ch];
		assign mac_rx_link.error = mac_rx_error[ch];
		assign mac_rx_link.valid = mac_rx_valid[ch];
		assign mac_rx_ready[ch] = mac_rx_link.ready;

		assign ptp_rx_data[ch] = ptp_rx_link.data;
		assign ptp_rx_empty[ch] = ptp_rx_link.empty;
		assign ptp_rx_sop[ch] = ptp_rx_link.sop;
		assign ptp_rx_eop[ch] = ptp_rx_link.eop;
		assign ptp_rx_error[ch] = ptp_rx_link.error;
		assign ptp_rx_valid[ch] = ptp_rx_link.valid;
		assign ptp_rx_link.ready = ptp_rx_ready[ch];

		assign std_rx_data[ch] = std_rx_link.data;
		assign std_rx_empty[ch] = std_rx_link.empty;
		assign std_rx_sop[ch] = std_rx_link.sop;
		assign std_rx_eop[ch] = std_rx_link.eop;
		assign std_rx_error[ch] = std_rx_link.error;
		assign std_rx_valid[ch] = std_rx_link.valid;
		assign std_rx_link.ready = std_rx_ready[ch];

		channel_stream_switch i_channel_stream_switch (
			.clk(clk),
			.rst(rst),
			.requested_path(requested_path),
			.active_path(active_path[ch]),
			.ptp_tx(ptp_tx_link.sink),
			.std_tx(std_tx_link.sink),
			.mac_tx(mac_tx_link.source),
			.mac_rx(mac_rx_link.sink),
			.ptp_rx(ptp_rx_link.source),
			.std_rx(std_rx_link.source)
		);
	end

endmodule

/* source/channel_stream_switch.sv */
/*
 * Stream switch for one channel. The active engine's transmit stream
 * goes to the MAC, and the MAC receive stream is steered back to that
 * same engine. A new path is taken only when neither direction is
 * inside a packet, so packets are never split between engines.
 */

`timescale 1ns/1ps

module channel_stream_switch (
	input logic clk,
	input logic rst,
	input logic requested_path,
	output logic active_path,
	st_link_if.sink ptp_tx,
	st_link_if.sink std_tx,
	st_link_if.source mac_tx,
	st_link_if.sink mac_rx,
	st_link_if.source ptp_rx,
	st_link_if.source std_rx
);
	import traffic_pkg::*;

	logic active_q;
	logic use_ptp;
	logic tx_open;
	logic rx_open;
	logic tx_beat;
	logic rx_beat;
	logic tx_start;
	logic rx_start;
	logic boundary;

	//////////////////////////////
	// packet tracking
	assign tx_beat = mac_tx.valid & mac_tx.ready;
	assign rx_beat = mac_rx.valid & mac_rx.ready;
	assign tx_start = tx_beat & mac_tx.sop & ~mac_tx.eop;
	assign rx_start = rx_beat & mac_rx.sop & ~mac_rx.eop;

	// a packet starting on this edge counts as open
	assign boundary = ~tx_open & ~rx_open & ~tx_start & ~rx_start;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			active_q <= path_std;
			tx_open <= 1'b0;
			rx_open <= 1'b0;
		end
		else
		begin
			if (tx_beat)
				tx_open <= tx_start | (tx_open & ~mac_tx.eop);
			if (rx_beat)
				rx_open <= rx_start | (rx_open & ~mac_rx.eop);
			if (boundary)
				active_q <= requested_path;
		end
	end

	assign active_path = active_q;
	assign use_ptp = (active_q == path_ptp);

	//////////////////////////////
	// transmit mux
	assign mac_tx.data = use_ptp ? ptp_tx.data : std_tx.data;
	assign mac_tx.empty = use_ptp ? ptp_tx.empty : std_tx.empty;
	assign mac_tx.sop = use_ptp ? ptp_tx.sop : std_tx.sop;
	assign mac_tx.eop = use_ptp ? ptp_tx.eop : std_tx.eop;
	assign mac_tx.error = use_ptp ? ptp_tx.error : std_tx.error;
	assign mac_tx.valid = use_ptp ? ptp_tx.valid : std_tx.valid;

	// idle engine is held off
	assign ptp_tx.ready = use_ptp & mac_tx.ready;
	assign std_tx.ready = ~use_ptp & mac_tx.ready;

	//////////////////////////////
	// receive demux
	assign ptp_rx.data = mac_rx.data;
	assign ptp_rx.empty = mac_rx.empty;
	assign ptp_rx.sop = mac_rx.sop;
	assign ptp_rx.eop = mac_rx.eop;
	assign ptp_rx.error = mac_rx.error;
	assign ptp_rx.valid = use_ptp & mac_rx.valid;

	assign std_rx.data = mac_rx.data;
	assign std_rx.empty = mac_rx.empty;
	assign std_rx.sop = mac_rx.sop;
	assign std_rx.eop = mac_rx.eop;
	assign std_rx.error = mac_rx.error;
	assign std_rx.valid = ~use_ptp & mac_rx.valid;

	assign mac_rx.ready = use_ptp ? ptp_rx.ready : std_rx.ready;

endmodule

/* source/path_select_csr.sv */
/*
 * Path-select register on the control bus.
 * Offset 0: requested traffic engine in bit 0, read/write.
 * Offset 1: active path of each channel, one bit per channel, read only.
 * Writes complete at once, reads take one wait cycle.
 */

`timescale 1ns/1ps

module path_select_csr #(
	parameter int NUM_CHANNELS = traffic_pkg::num_channels_default
) (
	input logic clk,
	input logic rst,
	csr_bus_if.target bus,
	input logic [NUM_CHANNELS-1:0] active_path,
	output logic requested_path
);
	import traffic_pkg::*;

	// set in the wait cycle, so the read completes on the next one
	logic rd_ack;

	assign bus.waitrequest = bus.read & ~rd_ack;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_ack <= 1'b0;
			bus.readdata <= '0;
			requested_path <= path_std;
		end
		else
		begin
			rd_ack <= bus.read & ~rd_ack;

			if (bus.read & ~rd_ack)
			begin
				if (bus.address == 1'b0)
					bus.readdata <= csr_word_t'(requested_path);
				else
					bus.readdata <= csr_word_t'(active_path);
			end

			// offset 1 ignores writes
			if (bus.write && bus.address == 1'b0)
				requested_path <= bus.writedata[0];
		end
	end

endmodule

/* source/csr_address_decoder.sv */
/*
 * Splits the host control bus into four regions by the top two address
 * bits: ptp engine, select register, and one standard engine per channel.
 * Purely combinational. Strobes reach only the addressed target, and its
 * readdata and waitrequest are returned to the host.
 */

`timescale 1ns/1ps

module csr_address_decoder #(
	parameter int NUM_CHANNELS = traffic_pkg::num_channels_default
) (
	input logic clk,
	input logic rst,
	csr_bus_if.target host,
	csr_bus_if.host select_bus,
	output logic ptp_read,
	output logic ptp_write,
	output logic [7:0] ptp_address,
	input traffic_pkg::csr_word_t ptp_readdata,
	input logic ptp_waitrequest,
	output logic [NUM_CHANNELS-1:0] std_read,
	output logic [NUM_CHANNELS-1:0] std_write,
	output logic [traffic_pkg::offset_w-1:0] std_address,
	input traffic_pkg::csr_word_t [NUM_CHANNELS-1:0] std_readdata,
	input logic [NUM_CHANNELS-1:0] std_waitrequest,
	output traffic_pkg::csr_word_t writedata_out
);
	import traffic_pkg::*;

	csr_addr_u addr;
	logic sel_ptp;
	logic sel_select;
	logic [NUM_CHANNELS-1:0] sel_std;

	assign addr.raw = host.address;

	//////////////////////////////
	// region match
	assign sel_ptp = (addr.split.region == region_ptp);
	assign sel_select = (addr.split.region == region_select);

	always_comb
	begin
		for (int ch = 0; ch < NUM_CHANNELS; ch++)
			sel_std[ch] = (addr.split.region == region_w'(region_std0 + ch));
	end

	//////////////////////////////
	// request side
	assign ptp_read = host.read & sel_ptp;
	assign ptp_write = host.write & sel_ptp;
	assign ptp_address = addr.split.offset[7:0];

	assign select_bus.read = host.read & sel_select;
	assign select_bus.write = host.write & sel_select;
	assign select_bus.address = addr.split.offset[0];
	assign select_bus.writedata = host.writedata;

	assign std_read = {NUM_CHANNELS{host.read}} & sel_std;
	assign std_write = {NUM_CHANNELS{host.write}} & sel_std;
	assign std_address = addr.split.offset;

	// only the strobed target looks at it
	assign writedata_out = host.writedata;

	//////////////////////////////
	// response from the addressed target
	always_comb
	begin
		host.readdata = '0;
		host.waitrequest = 1'b0;
		if (sel_ptp)
		begin
			host.readdata = ptp_readdata;
			host.waitrequest = ptp_waitrequest;
		end
		else if (sel_select)
		begin
			host.readdata = select_bus.readdata;
			host.waitrequest = select_bus.waitrequest;
		end
		else
		begin
			for (int ch = 0; ch < NUM_CHANNELS; ch++)
				if (sel_std[ch])
				begin
					host.readdata = std_readdata[ch];
					host.waitrequest = std_waitrequest[ch];
				end
		end
	end

endmodule

/* source/st_link_if.sv */
/*
 * One packet stream link between a source and a sink.
 * A beat moves on a cycle with valid and ready both high,
 * and the source holds it until then. Error width is set per link.
 */

`timescale 1ns/1ps

interface st_link_if #(
	parameter int ERROR_W = traffic_pkg::rx_error_w
);
	import traffic_pkg::*;

	st_data_t data;
	logic [st_empty_w-1:0] empty;
	logic sop;
	logic eop;
	logic [ERROR_W-1:0] error;
	logic valid;
	logic ready;

	modport source (
		output data, empty, sop, eop, error, valid,
		input ready
	);

	modport sink (
		input data, empty, sop, eop, error, valid,
		output ready
	);

endinterface

/* source/csr_bus_if.sv */
/*
 * Memory-mapped control bus with waitrequest handshake.
 * An access holds its fields until a cycle with waitrequest low,
 * which completes it and, for a read, carries readdata.
 */

`timescale 1ns/1ps

interface csr_bus_if #(
	parameter int ADDR_W = traffic_pkg::csr_addr_w
);
	import traffic_pkg::*;

	logic read;
	logic write;
	logic [ADDR_W-1:0] address;
	csr_word_t writedata;
	csr_word_t readdata;
	logic waitrequest;

	modport host (
		output read, write, address, writedata,
		input readdata, waitrequest
	);

	modport target (
		input read, write, address, writedata,
		output readdata, waitrequest
	);

endinterface

/* source/traffic_pkg.sv */
/*
 * Shared widths, region codes, path codes and types for the traffic
 * routing fabric. Modules import this inside their body and use scoped
 * names in their port lists.
 */

package traffic_pkg;

	//////////////////////////////
	// widths
	parameter int num_channels_default = 2;
	parameter int csr_addr_w = 14;
	parameter int region_w = 2;
	parameter int offset_w = 12;
	parameter int csr_data_w = 32;
	parameter int st_data_w = 64;
	parameter int st_empty_w = 3;
	parameter int tx_error_w = 1;
	parameter int rx_error_w = 6;

	//////////////////////////////
	// host address regions by the top two address bits
	localparam logic [region_w-1:0] region_ptp = 2'd0;
	localparam logic [region_w-1:0] region_select = 2'd1;
	localparam logic [region_w-1:0] region_std0 = 2'd2;
	localparam logic [region_w-1:0] region_std1 = 2'd3;

	// traffic engine choice
	// std out of reset since the ptp engine is parked
	localparam logic path_ptp = 1'b0;
	localparam logic path_std = 1'b1;

	typedef logic [csr_data_w-1:0] csr_word_t;
	typedef logic [st_data_w-1:0] st_data_t;

	// host address seen as a raw word or as region plus offset
	typedef union packed {
		logic [csr_addr_w-1:0] raw;
		struct packed {
			logic [region_w-1:0] region;
			logic [offset_w-1:0] offset;
		} split;
	} csr_addr_u;

endpackage
